//--- build.f
+incdir+hw
hw/vscale_pkg.sv
hw/line_ram_if.sv
hw/bilinear_scaler.sv
hw/line_store.sv
hw/line_blender.sv
hw/line_ram_arbiter.sv
hw/vscale_top.sv
verif/vscale_asserts.sv
verif/vscale_tb.sv

//--- Bender.yml
package:
  name: vscale

sources:
  - include_dirs:
      - hw
    files:
      - hw/vscale_pkg.sv
      - hw/line_ram_if.sv
      - hw/bilinear_scaler.sv
      - hw/line_store.sv
      - hw/line_blender.sv
      - hw/line_ram_arbiter.sv
      - hw/vscale_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/vscale_asserts.sv
      - verif/vscale_tb.sv

//--- verif/vscale_trace.txt
# per test: name, input lines, output lines, gap mode (0 fixed 2 cycles, 1 random 2..6)
# then input pixels and expected output pixels in hex, two image lines per row
up_4_to_6 4 6 0
00 ff 00 ff 00 ff 00 ff 80 40 80 40 80 40 80 40
10 20 30 40 50 60 70 80 ff 00 ff 00 ff 00 ff 00
00 ff 00 ff 00 ff 00 ff 40 9f 40 9f 40 9f 40 9f
64 38 6c 40 74 48 7c 50 10 20 30 40 50 60 70 80
87 10 97 20 a7 30 b7 40 ff 00 ff 00 ff 00 ff 00
down_6_to_4 6 4 0
00 ff 00 ff 00 ff 00 ff ff 00 ff 00 ff 00 ff 00
11 22 33 44 55 66 77 88 40 c0 40 c0 40 c0 40 c0
c0 40 c0 40 c0 40 c0 40 01 02 03 04 05 06 07 08
3f bf 3f bf 3f bf 3f bf 11 22 33 44 55 66 77 88
60 a0 60 a0 60 a0 60 a0 01 02 03 04 05 06 07 08
same_4_to_4 4 4 0
12 34 56 78 9a bc de f0 aa 55 aa 55 aa 55 aa 55
55 aa 55 aa 55 aa 55 aa f0 de bc 9a 78 56 34 12
12 34 56 78 9a bc de f0 aa 55 aa 55 aa 55 aa 55
55 aa 55 aa 55 aa 55 aa f0 de bc 9a 78 56 34 12
one_to_3 1 3 0
0f 1e 2d 3c 4b 5a 69 78
0f 1e 2d 3c 4b 5a 69 78 0f 1e 2d 3c 4b 5a 69 78
0f 1e 2d 3c 4b 5a 69 78
up_random_gaps 4 6 1
00 ff 00 ff 00 ff 00 ff 80 40 80 40 80 40 80 40
10 20 30 40 50 60 70 80 ff 00 ff 00 ff 00 ff 00
00 ff 00 ff 00 ff 00 ff 40 9f 40 9f 40 9f 40 9f
64 38 6c 40 74 48 7c 50 10 20 30 40 50 60 70 80
87 10 97 20 a7 30 b7 40 ff 00 ff 00 ff 00 ff 00

//--- verif/vscale_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vscale_config.svh"

module vscale_tb
	import vscale_pkg::*;
();
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int QUIET_CYCLES = 30;
	localparam int CYCLES_PER_PIX = 20;
	localparam string TRACE_FILE = "verif/vscale_trace.txt";

	logic clk;
	logic resetn;
	reso_t i_ori_size;
	reso_t i_scale_size;
	logic i_pix_valid;
	pixel_t i_pix;
	logic o_line_req;
	logic o_pix_valid;
	pixel_t o_pix;
	logic o_frame_done;

	string test_name [$];
	int test_ori [$];
	int test_scale [$];
	int test_gap [$];
	pixel_t trace_pix [$];
	pixel_t in_q [$];
	pixel_t exp_q [$];
	int gap_mode;
	bit in_test;
	bit loaded;
	int watchdog_cycles;
	int err_cnt;
	int n_pass;
	int n_fail;
	int line_req_cnt;
	int pix_cnt;
	int frame_cnt;

	vscale_top i_vscale_top (
		.clk(clk),
		.resetn(resetn),
		.i_ori_size(i_ori_size),
		.i_scale_size(i_scale_size),
		.i_pix_valid(i_pix_valid),
		.i_pix(i_pix),
		.o_line_req(o_line_req),
		.o_pix_valid(o_pix_valid),
		.o_pix(o_pix),
		.o_frame_done(o_frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
			err_cnt++;
		end
	endtask

	// skips comment lines that start with a hash.
	task automatic next_token(input int fd, output string tok, output bit ok);
		string line;
		int n;
		ok = 1'b0;
		tok = "";
		while (!ok && !$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
				tok = "";
			else if (tok.len() > 0 && tok[0] == "#")
				n = $fgets(line, fd);
			else
				ok = 1'b1;
		end
	endtask

	task automatic read_number(input int fd, input bit hex, inout bit ok, output int val);
		string tok;
		int n;
		val = 0;
		if (ok) begin
			next_token(fd, tok, ok);
			if (ok) begin
				n = hex ? $sscanf(tok, "%h", val) : $sscanf(tok, "%d", val);
				ok = (n == 1);
			end
		end
	endtask

	task automatic load_trace(output bit ok);
		int fd;
		int c;
		int ori;
		int scale;
		int gap;
		int v;
		string name;
		bit got;
		bit bad;
		ok = 1'b0;
		bad = 1'b0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd != 0) begin
			got = 1'b1;
			while (got && !bad) begin
				next_token(fd, name, got);
				if (got) begin
					read_number(fd, 1'b0, got, ori);
					read_number(fd, 1'b0, got, scale);
					read_number(fd, 1'b0, got, gap);
					for (c = 0; got && c < (ori + scale) * `LINE_PIXELS; c++) begin
						read_number(fd, 1'b1, got, v);
						trace_pix.push_back(pixel_t'(v));
					end
					bad = !got || ori < 1 || scale < 1;
					test_name.push_back(name);
					test_ori.push_back(ori);
					test_scale.push_back(scale);
					test_gap.push_back(gap);
				end
			end
			$fclose(fd);
			ok = !bad && (test_name.size() != 0);
		end
	endtask

	// one line after a line request, pixels at least two cycles apart.
	task automatic send_line();
		int c;
		int gap;
		if (in_q.size() < `LINE_PIXELS) begin
			$display("line requested but no input line is left for this test");
			err_cnt++;
		end else begin
			@(negedge clk);
			for (c = 0; c < `LINE_PIXELS; c++) begin
				gap = (gap_mode != 0) ? 2 + int'($urandom % 5) : 2;
				i_pix_valid = 1'b1;
				i_pix = in_q.pop_front();
				@(negedge clk);
				i_pix_valid = 1'b0;
				repeat (gap - 1) @(negedge clk);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h5e60));
		forever begin
			@(negedge clk);
			if (resetn && o_line_req)
				send_line();
		end
	end

	always @(negedge clk) begin
		if (in_test && resetn) begin
			if ((o_line_req || o_pix_valid) && frame_cnt != 0) begin
				$display("output activity seen after o_frame_done");
				err_cnt++;
			end
			if (o_line_req)
				line_req_cnt++;
			if (o_pix_valid) begin
				pix_cnt++;
				if (exp_q.size() == 0) begin
					$display("output pixel %0d is beyond the expected frame", pix_cnt);
					err_cnt++;
				end else
					check_equal("o_pix", exp_q.pop_front(), o_pix);
			end
			if (o_frame_done)
				frame_cnt++;
		end
	end

	task automatic run_test(input int idx);
		int c;
		int errs_before;
		int fails_before;
		errs_before = err_cnt;
		fails_before = i_vscale_top.u_asserts.assert_fails;
		in_q.delete();
		exp_q.delete();
		for (c = 0; c < test_ori[idx] * `LINE_PIXELS; c++)
			in_q.push_back(trace_pix.pop_front());
		for (c = 0; c < test_scale[idx] * `LINE_PIXELS; c++)
			exp_q.push_back(trace_pix.pop_front());
		@(negedge clk);
		in_test = 1'b0;
		resetn = 1'b0;
		gap_mode = test_gap[idx];
		i_ori_size = reso_t'(test_ori[idx]);
		i_scale_size = reso_t'(test_scale[idx]);
		i_pix_valid = 1'b0;
		line_req_cnt = 0;
		pix_cnt = 0;
		frame_cnt = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		in_test = 1'b1;
		resetn = 1'b1;
		wait (frame_cnt != 0);
		// stay a while to catch late strobes.
		repeat (QUIET_CYCLES) @(negedge clk);
		check_equal("o_pix_valid count", test_scale[idx] * `LINE_PIXELS, pix_cnt);
		check_equal("o_frame_done count", 1, frame_cnt);
		check_equal("o_line_req count", test_ori[idx], line_req_cnt);
		if (i_vscale_top.u_asserts.assert_fails != fails_before) begin
			$display("protocol assertions failed during this test");
			err_cnt++;
		end
		if (err_cnt == errs_before) begin
			n_pass++;
			$display("test %s: ok", test_name[idx]);
		end else begin
			n_fail++;
			$display("test %s: failed with %0d errors", test_name[idx], err_cnt - errs_before);
		end
	endtask

	initial begin
		int t;
		bit load_ok;
		resetn = 1'b0;
		i_ori_size = '0;
		i_scale_size = '0;
		i_pix_valid = 1'b0;
		i_pix = '0;
		in_test = 1'b0;
		loaded = 1'b0;
		gap_mode = 0;
		err_cnt = 0;
		n_pass = 0;
		n_fail = 0;
		line_req_cnt = 0;
		pix_cnt = 0;
		frame_cnt = 0;
		load_trace(load_ok);
		if (!load_ok) begin
			$display("trace file %s is missing or malformed", TRACE_FILE);
			err_cnt++;
		end else begin
			watchdog_cycles = trace_pix.size() * CYCLES_PER_PIX
				+ test_name.size() * (RESET_CYCLES + QUIET_CYCLES + 2);
			loaded = 1'b1;
			for (t = 0; t < test_name.size(); t++)
				run_test(t);
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			n_pass + n_fail, n_pass, n_fail, err_cnt);
		if (err_cnt == 0 && n_fail == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (watchdog_cycles) @(posedge clk);
		$display("run timed out after %0d cycles", watchdog_cycles);
		$display("TESTS FAILED");
		$finish;
	end
endmodule

`default_nettype wire

//--- verif/vscale_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vscale_asserts
	import vscale_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire i_pix_valid,
	input wire i_store_armed,
	input wire i_wr_gnt,
	input wire i_rd_req,
	input wire i_rd_gnt,
	input wire ram_addr_t i_rd_addr,
	input wire i_frame_done
);
	logic frame_seen;
	// number of assertion failures so far.
	int assert_fails = 0;

	always_ff @(posedge clk) begin
		if (!resetn)
			frame_seen <= 1'b0;
		else if (i_frame_done)
			frame_seen <= 1'b1;
	end

	// a waiting requester keeps its request and address.
	rd_held: assert property (@(posedge clk) disable iff (!resetn)
		i_rd_req && !i_rd_gnt |=> i_rd_req && $stable(i_rd_addr))
		else begin
			$error("read request dropped before grant");
			assert_fails++;
		end

	one_grant: assert property (@(posedge clk) disable iff (!resetn)
		!(i_wr_gnt && i_rd_gnt))
		else begin
			$error("both RAM requesters granted in one cycle");
			assert_fails++;
		end

	// pixels outside an armed line would be lost.
	armed_pix: assert property (@(posedge clk) disable iff (!resetn)
		i_pix_valid |-> i_store_armed)
		else begin
			$error("input pixel while line store is not armed");
			assert_fails++;
		end

	frame_once: assert property (@(posedge clk) disable iff (!resetn)
		i_frame_done |-> !frame_seen)
		else begin
			$error("second frame done pulse in one frame");
			assert_fails++;
		end
endmodule

bind vscale_top vscale_asserts u_asserts (
	.clk(clk),
	.resetn(resetn),
	.i_pix_valid(i_pix_valid),
	.i_store_armed(u_store.armed),
	.i_wr_gnt(ram_wr.gnt),
	.i_rd_req(ram_rd.req),
	.i_rd_gnt(ram_rd.gnt),
	.i_rd_addr(ram_rd.addr),
	.i_frame_done(o_frame_done)
);

`default_nettype wire

//--- hw/vscale_top.sv
`timescale 1ns/1ps
`default_nettype none

module vscale_top
	import vscale_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire reso_t i_ori_size,
	input wire reso_t i_scale_size,
	input wire i_pix_valid,
	input wire pixel_t i_pix,
	output wire o_line_req,
	output wire o_pix_valid,
	output wire pixel_t o_pix,
	output wire o_frame_done
);
	logic update_mul;
	logic repeat_line;
	logic ovalid;
	ratio_t ratio;
	reso_t inv_cnt;
	logic line_done;

	line_ram_if ram_wr ();
	line_ram_if ram_rd ();

	bilinear_scaler u_scaler (
		.clk(clk),
		.resetn(resetn),
		.i_ori_size(i_ori_size),
		.i_scale_size(i_scale_size),
		.i_update_mul(update_mul),
		.o_repeat_line(repeat_line),
		.o_m_inv_cnt(),
		.o_inv_cnt(inv_cnt),
		.o_ovalid(ovalid),
		.o_ratio(ratio)
	);

	line_store u_store (
		.clk(clk),
		.resetn(resetn),
		.i_pix_valid(i_pix_valid),
		.i_pix(i_pix),
		.i_line_req(o_line_req),
		.o_line_done(line_done),
		.ram(ram_wr.requester)
	);

	line_blender u_blender (
		.clk(clk),
		.resetn(resetn),
		.i_repeat_line(repeat_line),
		.i_ovalid(ovalid),
		.i_ratio(ratio),
		.i_inv_cnt(inv_cnt),
		.o_update_mul(update_mul),
		.o_line_req(o_line_req),
		.i_line_done(line_done),
		.o_pix_valid(o_pix_valid),
		.o_pix(o_pix),
		.o_frame_done(o_frame_done),
		.ram(ram_rd.requester)
	);

	line_ram_arbiter u_arbiter (
		.clk(clk),
		.resetn(resetn),
		.wr(ram_wr.arbiter),
		.rd(ram_rd.arbiter)
	);
endmodule

`default_nettype wire

//--- hw/line_ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram_arbiter
	import vscale_pkg::*;
(
	input wire clk,
	input wire resetn,
	line_ram_if.arbiter wr,
	line_ram_if.arbiter rd
);
	// two banks of one line each.
	localparam int DEPTH = 2 ** $bits(ram_addr_t);

	pixel_t mem [DEPTH];
	pixel_t rdata_q;
	logic sel_wr;
	logic port_en;
	logic port_we;
	ram_addr_t port_addr;
	pixel_t port_wdata;

	// fixed priority, the write side always wins.
	assign sel_wr = wr.req;
	assign wr.gnt = wr.req;
	assign rd.gnt = rd.req && !wr.req;

	assign port_en = wr.req || rd.req;
	assign port_we = sel_wr ? wr.we : rd.we;
	assign port_addr = sel_wr ? wr.addr : rd.addr;
	assign port_wdata = sel_wr ? wr.wdata : rd.wdata;

	assign wr.rdata = rdata_q;
	assign rd.rdata = rdata_q;

	// no RAM update while the design is held in reset.
	always_ff @(posedge clk) begin
		if (resetn && port_en && port_we)
			mem[port_addr] <= port_wdata;
	end

	always_ff @(posedge clk) begin
		if (port_en && !port_we)
			rdata_q <= mem[port_addr];
	end
endmodule

`default_nettype wire

//--- hw/line_blender.sv
`timescale 1ns/1ps
`default_nettype none

module line_blender
	import vscale_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire i_repeat_line,
	input wire i_ovalid,
	input wire ratio_t i_ratio,
	input wire reso_t i_inv_cnt,
	output logic o_update_mul,
	output logic o_line_req,
	input wire i_line_done,
	output logic o_pix_valid,
	output pixel_t o_pix,
	output logic o_frame_done,
	line_ram_if.requester ram
);
	localparam int ACC_WIDTH = $bits(pixel_t) + 3;

	blend_state_t state;
	col_t col;
	logic wr_par;
	logic newer_bank;
	logic older_bank;
	logic have_line;
	logic have_two;
	logic rd_ack;
	pixel_t old_q;
	logic [ACC_WIDTH-1:0] acc;

	// until a second line is in, both taps point at the same bank.
	assign older_bank = have_two ? ~newer_bank : newer_bank;

	assign o_line_req = (state == REQ_LINE);
	assign o_update_mul = (state == STEP);

	assign ram.req = (state == READ_OLD) || (state == READ_NEW);
	assign ram.we = 1'b0;
	assign ram.wdata = '0;
	assign ram.addr = (state == READ_NEW) ? {newer_bank, col} : {older_bank, col};

	// newer pixel is on rdata while in EMIT.
	always_comb begin
		acc = ACC_WIDTH'(old_q) * ACC_WIDTH'(3'd4 - i_ratio)
			+ ACC_WIDTH'(ram.rdata) * ACC_WIDTH'(i_ratio);
	end

	always_ff @(posedge clk) begin
		if (state == READ_NEW && rd_ack)
			old_q <= ram.rdata;
		if (state == EMIT)
			o_pix <= pixel_t'(acc >> 2);
	end

	// mirror of the store parity, so the newest bank is known here.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_par <= 1'b0;
			newer_bank <= 1'b0;
			have_line <= 1'b0;
			have_two <= 1'b0;
		end else if (i_line_done) begin
			wr_par <= ~wr_par;
			newer_bank <= wr_par;
			have_line <= 1'b1;
			have_two <= have_line;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			col <= '0;
			rd_ack <= 1'b0;
			o_pix_valid <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			o_pix_valid <= 1'b0;
			o_frame_done <= 1'b0;
			rd_ack <= ram.req && ram.gnt;
			case (state)
			IDLE: begin
				if (i_inv_cnt == '0) begin
					state <= DONE;
					o_frame_done <= 1'b1;
				end else if (!i_repeat_line)
					state <= REQ_LINE;
				else if (i_ovalid)
					state <= READ_OLD;
				else
					state <= STEP;
			end
			REQ_LINE:
				state <= WAIT_LINE;
			WAIT_LINE: begin
				if (i_line_done)
					state <= i_ovalid ? READ_OLD : STEP;
			end
			READ_OLD: begin
				if (ram.gnt)
					state <= READ_NEW;
			end
			READ_NEW: begin
				if (ram.gnt)
					state <= EMIT;
			end
			EMIT: begin
				o_pix_valid <= 1'b1;
				col <= col + 1'b1;
				state <= (col == '1) ? STEP : READ_OLD;
			end
			STEP:
				state <= IDLE;
			DONE:
				state <= DONE;
			default:
				state <= IDLE;
			endcase
		end
	end
endmodule

`default_nettype wire

//--- hw/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store
	import vscale_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire i_pix_valid,
	input wire pixel_t i_pix,
	input wire i_line_req,
	output logic o_line_done,
	line_ram_if.requester ram
);
	logic armed;
	logic wr_req;
	logic bank;
	col_t col;
	pixel_t pix_q;

	assign ram.req = wr_req;
	assign ram.we = 1'b1;
	assign ram.addr = {bank, col};
	assign ram.wdata = pix_q;

	always_ff @(posedge clk) begin
		if (armed && i_pix_valid)
			pix_q <= i_pix;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			armed <= 1'b0;
			wr_req <= 1'b0;
			bank <= 1'b0;
			col <= '0;
			o_line_done <= 1'b0;
		end else begin
			o_line_done <= 1'b0;
			if (i_line_req)
				armed <= 1'b1;
			if (wr_req && ram.gnt) begin
				wr_req <= 1'b0;
				// column wraps back to zero after the last pixel.
				col <= col + 1'b1;
				if (col == '1) begin
					armed <= 1'b0;
					bank <= ~bank;
					o_line_done <= 1'b1;
				end
			end
			// strobes outside an armed line are dropped.
			if (armed && i_pix_valid)
				wr_req <= 1'b1;
		end
	end
endmodule

`default_nettype wire

//--- hw/bilinear_scaler.sv
`timescale 1ns/1ps
`default_nettype none

`include "vscale_config.svh"

module bilinear_scaler
	import vscale_pkg::*;
#(
	parameter int C_RESO_WIDTH = `RESO_WIDTH
) (
	input wire clk,
	input wire resetn,
	input wire reso_t i_ori_size,
	input wire reso_t i_scale_size,
	input wire i_update_mul,
	output logic o_repeat_line,
	output reso_t o_m_inv_cnt,
	output reso_t o_inv_cnt,
	output logic o_ovalid,
	output ratio_t o_ratio
);
	localparam int C_CMP_WIDTH = C_RESO_WIDTH * 2 + 2;

	logic [C_CMP_WIDTH-1:0] ori_w;
	logic [C_CMP_WIDTH-1:0] scale_w;
	logic [C_CMP_WIDTH-1:0] ori_x2;
	logic [C_CMP_WIDTH-1:0] scale_x2;
	logic [C_CMP_WIDTH-1:0] scale_x3;
	logic [C_CMP_WIDTH-1:0] scale_q4;
	logic [C_CMP_WIDTH-1:0] m_mul;
	logic [C_CMP_WIDTH-1:0] o_mul;
	logic [C_CMP_WIDTH-1:0] o_mul_next;
	logic [C_CMP_WIDTH-1:0] m_split [4];
	logic m_repeat;
	logic need_line;
	logic update_mmul;
	logic update_omul;

	// sizes are taken while in reset and kept for the frame.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ori_w <= C_CMP_WIDTH'(i_ori_size);
			scale_w <= C_CMP_WIDTH'(i_scale_size);
		end
	end

	assign ori_x2 = ori_w << 1;
	assign scale_x2 = scale_w << 1;
	assign scale_x3 = scale_x2 + scale_w;
	assign scale_q4 = scale_w >> 2;

	// input line k sits at (2k+1)*scale, output line j at (2j+1)*ori.
	assign m_repeat = m_mul >= o_mul_next;
	assign o_ovalid = m_mul >= o_mul;
	assign update_mmul = i_update_mul && !m_repeat;
	assign update_omul = i_update_mul && o_ovalid;
	assign o_repeat_line = !need_line;

	always_comb begin
		if (o_mul >= m_split[2])
			o_ratio = (o_mul >= m_split[3]) ? 3'd4 : 3'd3;
		else if (o_mul >= m_split[1])
			o_ratio = 3'd2;
		else if (o_mul >= m_split[0])
			o_ratio = 3'd1;
		else
			o_ratio = 3'd0;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			m_mul <= (i_ori_size == 1) ? (C_CMP_WIDTH'(i_scale_size) << 1)
				: C_CMP_WIDTH'(i_scale_size);
		else if (update_mmul && o_m_inv_cnt == 2)
			// the last line is pushed out by half a stride to extend the bottom.
			m_mul <= m_mul + scale_x3;
		else if (update_mmul && o_m_inv_cnt != 1)
			m_mul <= m_mul + scale_x2;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < 4; i++)
				m_split[i] <= C_CMP_WIDTH'(i_scale_size);
		end else if (update_mmul && o_m_inv_cnt == 1) begin
			for (int i = 0; i < 4; i++)
				m_split[i] <= m_mul;
		end else if (update_mmul) begin
			m_split[0] <= m_mul + scale_q4;
			m_split[1] <= m_mul + scale_w - scale_q4;
			m_split[2] <= m_mul + scale_w + scale_q4;
			m_split[3] <= m_mul + scale_w;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_mul <= C_CMP_WIDTH'(i_ori_size);
			o_mul_next <= C_CMP_WIDTH'(i_ori_size) * 3;
			o_inv_cnt <= i_scale_size;
		end else if (update_omul) begin
			o_mul <= o_mul_next;
			o_mul_next <= o_mul_next + ori_x2;
			o_inv_cnt <= o_inv_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_m_inv_cnt <= i_ori_size;
		else if (update_mmul && o_m_inv_cnt != 1)
			o_m_inv_cnt <= o_m_inv_cnt - 1'b1;
	end

	// first line is always fetched, the last one is never fetched twice.
	always_ff @(posedge clk) begin
		if (!resetn)
			need_line <= 1'b1;
		else if (i_update_mul)
			need_line <= !m_repeat && (o_m_inv_cnt != 1);
	end
endmodule

`default_nettype wire

//--- hw/line_ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_ram_if
	import vscale_pkg::*;
();
	logic req;
	logic we;
	ram_addr_t addr;
	pixel_t wdata;
	logic gnt;
	// valid one cycle after a granted read.
	pixel_t rdata;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input gnt,
		input rdata
	);

	modport arbiter (
		input req,
		input we,
		input addr,
		input wdata,
		output gnt,
		output rdata
	);

	modport monitor (
		input req,
		input we,
		input addr,
		input wdata,
		input gnt,
		input rdata
	);
endinterface

`default_nettype wire

//--- hw/vscale_pkg.sv
`default_nettype none

`include "vscale_config.svh"

package vscale_pkg;

	typedef logic [`PIX_WIDTH-1:0] pixel_t;
	typedef logic [`RESO_WIDTH-1:0] reso_t;

	// weight of the newer line in quarters, 0..4.
	typedef logic [2:0] ratio_t;

	typedef logic [$clog2(`LINE_PIXELS)-1:0] col_t;

	// bank bit on top of the column index.
	typedef logic [$clog2(`LINE_PIXELS):0] ram_addr_t;

	typedef enum logic [2:0] {
		IDLE,
		REQ_LINE,
		WAIT_LINE,
		READ_OLD,
		READ_NEW,
		EMIT,
		STEP,
		DONE
	} blend_state_t;

endpackage

`default_nettype wire

//--- hw/vscale_config.svh
`ifndef VSCALE_CONFIG_SVH
`define VSCALE_CONFIG_SVH

// bits per grayscale pixel.
`define PIX_WIDTH 8

// width of a line count or a frame size.
`define RESO_WIDTH 10

// pixels per line, any power of two.
`define LINE_PIXELS 8

`endif
